// File: flist.f
wb_pkg.sv
mw_pipe_reg.sv
wb_decoder.sv
wb_datapath.sv
grf.sv
wb_stage_top.sv
wb_checker.sv
wb_tb.sv

// File: grf.sv
`timescale 1ns/1ps
`default_nettype none

module grf (
	input  logic                clk,
	input  logic                rst_n,
	input  wb_pkg::grf_wr_t     wr,
	input  logic [4:0]          ra1,
	input  logic [4:0]          ra2,
	output logic [31:0]         rd1,
	output logic [31:0]         rd2
);

	// Register 0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.we && wr.addr != 5'd0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Zero register, then bypass of the retiring write, then array
	function automatic logic [31:0] read_port(input logic [4:0] ra);
		logic [31:0] val;
		if (ra == 5'd0) begin
			val = '0;
		end else if (wr.we && wr.addr == ra) begin
			val = wr.data;
		end else begin
			val = regs[ra];
		end
		return val;
	endfunction

	assign rd1 = read_port(ra1);
	assign rd2 = read_port(ra2);

	// Datapath is expected to squash $zero writes before they arrive
	a_no_zero_write: assert property (
		@(posedge clk) disable iff (!rst_n) !(wr.we && wr.addr == 5'd0)
	) else $error("grf: write to register 0");

endmodule

`default_nettype wire

// File: mw_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mw_pipe_reg (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               stall,
	input  logic               flush,
	input  wb_pkg::mw_bundle_t d,
	output wb_pkg::mw_bundle_t q
);

	// Payload follows d unless stalled
	// Valid is cleared by reset or flush, flush wins over stall
	always_ff @(posedge clk) begin
		if (!stall) begin
			q <= d;
		end
		if (!rst_n || flush) begin
			q.valid <= 1'b0;
		end
	end

	// A flushed slot must never retire
	a_flush_kills: assert property (@(posedge clk) flush |=> !q.valid)
		else $error("mw_pipe_reg: valid set after flush");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module wb_tb -o wb_sim
./obj_dir/wb_sim | tee sim.log

if grep -q "^Done: no errors$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: wb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module wb_checker #(
	parameter int LINK_OFFSET = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               stall,
	input  logic               flush,
	input  wb_pkg::mw_bundle_t mw_in,
	input  logic [4:0]         ra1,
	input  logic [4:0]         ra2,
	input  logic [31:0]        rd1,
	input  logic [31:0]        rd2,
	input  wb_pkg::grf_wr_t    fwd,
	input  string              test_name,
	input  logic [31:0]        exp_val,
	input  logic               check_en,
	output int                 errors,
	output int                 tests_run,
	output int                 tests_failed
);

	logic [31:0] model_regs [0:31];
	wb_pkg::mw_bundle_t model_stage;
	logic primed = 1'b0;
	int test_errs = 0;
	int n_err = 0;
	int n_run = 0;
	int n_fail = 0;

	assign errors       = n_err;
	assign tests_run    = n_run;
	assign tests_failed = n_fail;

	// Write that a held bundle should retire
	function automatic wb_pkg::grf_wr_t expected_write(input wb_pkg::mw_bundle_t b);
		wb_pkg::grf_wr_t p;
		logic [5:0] op;
		logic [7:0] lane8;
		logic [15:0] lane16;
		op = b.instr[31:26];
		lane8 = 8'(b.mem_rdata >> (8 * b.byte_off));
		lane16 = 16'(b.mem_rdata >> (16 * b.byte_off[1]));
		p.we = 1'b1;
		p.addr = b.instr[20:16];
		p.data = b.alu_result;
		case (op)
			wb_pkg::OP_SPECIAL: begin
				p.addr = b.instr[15:11];
				p.we = b.instr[5:0] inside {wb_pkg::FN_ADD, wb_pkg::FN_SUB, wb_pkg::FN_OR,
					wb_pkg::FN_AND, wb_pkg::FN_SLT, wb_pkg::FN_SLTU};
			end
			wb_pkg::OP_ORI, wb_pkg::OP_LUI, wb_pkg::OP_ADDI, wb_pkg::OP_ANDI: ;
			wb_pkg::OP_LW: p.data = b.mem_rdata;
			wb_pkg::OP_LB: p.data = {{24{lane8[7]}}, lane8};
			wb_pkg::OP_LH: p.data = {{16{lane16[15]}}, lane16};
			wb_pkg::OP_JAL: begin
				p.addr = 5'd31;
				p.data = b.pc + 32'(LINK_OFFSET);
			end
			default: p.we = 1'b0;
		endcase
		if (!b.valid || p.addr == 5'd0) begin
			p.we = 1'b0;
		end
		return p;
	endfunction

	////////////////////////////////////////
	// Model of the M/W buffer and registers
	////////////////////////////////////////
	always @(posedge clk) begin
		wb_pkg::grf_wr_t p;
		if (!rst_n) begin
			model_regs = '{default: '0};
			model_stage = '0;
		end else begin
			p = expected_write(model_stage);
			if (p.we) begin
				model_regs[p.addr] = p.data;
			end
			if (!stall) begin
				model_stage = mw_in;
			end
			if (flush) begin
				model_stage.valid = 1'b0;
			end
		end
		primed = 1'b1;
	end

	// Mid-cycle compare, all inputs settled
	always @(negedge clk) begin
		wb_pkg::grf_wr_t p;
		logic [31:0] model_val;
		logic [31:0] model_val2;
		if (primed) begin
			p = expected_write(model_stage);
			if (fwd.we && !p.we) begin
				$display("Unexpected write in %s: r%0d written while no write was due",
					test_name, fwd.addr);
				test_errs++;
			end else if (p.we && fwd !== p) begin
				$display("ERR %s: fwd expected r%0d=%h actual we=%b r%0d=%h", test_name,
					p.addr, p.data, fwd.we, fwd.addr, fwd.data);
				test_errs++;
			end
			if (p.we && ra1 == p.addr && rd1 !== p.data) begin
				$display("ERR %s: bypass read r%0d expected %h actual %h", test_name,
					ra1, p.data, rd1);
				test_errs++;
			end
			// Second read port, array or bypass
			model_val2 = (ra2 == 5'd0) ? 32'h0 : model_regs[ra2];
			if (p.we && p.addr == ra2) begin
				model_val2 = p.data;
			end
			if (rd2 !== model_val2) begin
				$display("ERR %s: port 2 r%0d expected %h actual %h", test_name,
					ra2, model_val2, rd2);
				test_errs++;
			end
			if (check_en) begin
				model_val = (ra1 == 5'd0) ? 32'h0 : model_regs[ra1];
				if (p.we && p.addr == ra1) begin
					model_val = p.data;
				end
				if (rd1 !== exp_val) begin
					$display("ERR %s: r%0d expected %h actual %h", test_name, ra1, exp_val, rd1);
					test_errs++;
				end else if (rd1 !== model_val) begin
					$display("ERR %s: r%0d model expected %h actual %h", test_name, ra1,
						model_val, rd1);
					test_errs++;
				end
				n_run++;
				if (test_errs == 0) begin
					$display("PASS %s", test_name);
				end else begin
					$display("FAIL %s (%0d errors)", test_name, test_errs);
					n_fail++;
				end
				n_err += test_errs;
				test_errs = 0;
			end
		end
	end

endmodule

`default_nettype wire

// File: wb_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module wb_datapath #(
	parameter int LINK_OFFSET = 8
) (
	input  wb_pkg::mw_bundle_t w,
	input  wb_pkg::wb_ctrl_t   ctrl,
	output wb_pkg::grf_wr_t    wr
);

	logic [7:0]  lane_byte;
	logic [15:0] lane_half;
	logic [31:0] load_val;
	logic [31:0] link_addr;
	logic [4:0]  dest;

	////////////////////////////////////////
	// Load lane extraction, little-endian
	////////////////////////////////////////
	assign lane_byte = w.mem_rdata[{w.byte_off, 3'b000} +: 8];
	// Halfword picked by offset bit 1 only
	assign lane_half = w.byte_off[1] ? w.mem_rdata[31:16] : w.mem_rdata[15:0];

	always_comb begin
		case (ctrl.load_kind)
			wb_pkg::LOAD_BYTE: load_val = {{24{lane_byte[7]}}, lane_byte};
			wb_pkg::LOAD_HALF: load_val = {{16{lane_half[15]}}, lane_half};
			default:           load_val = w.mem_rdata;
		endcase
	end

	assign link_addr = w.pc + 32'(LINK_OFFSET);

	////////////////////////////////////////
	// Data and destination select
	////////////////////////////////////////
	always_comb begin
		case (ctrl.wdata_sel)
			wb_pkg::WDATA_MEM:  wr.data = load_val;
			wb_pkg::WDATA_LINK: wr.data = link_addr;
			default:            wr.data = w.alu_result;
		endcase
	end

	always_comb begin
		case (ctrl.wreg_sel)
			wb_pkg::WREG_RT: dest = ctrl.rt;
			wb_pkg::WREG_RA: dest = 5'd31;
			default:         dest = ctrl.rd;
		endcase
	end

	assign wr.addr = dest;
	// Writes to $zero are dropped here, so grf never sees them
	assign wr.we   = w.valid && ctrl.grf_we && (dest != 5'd0);

endmodule

`default_nettype wire

// File: wb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_decoder (
	input  logic [31:0]      instr,
	output wb_pkg::wb_ctrl_t ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		ctrl           = '0;
		ctrl.wdata_sel = wb_pkg::WDATA_ALU;
		ctrl.wreg_sel  = wb_pkg::WREG_RD;
		ctrl.load_kind = wb_pkg::LOAD_WORD;
		ctrl.rt        = instr[20:16];
		ctrl.rd        = instr[15:11];

		case (opcode)
			wb_pkg::OP_SPECIAL: begin
				case (funct)
					wb_pkg::FN_ADD, wb_pkg::FN_SUB, wb_pkg::FN_OR,
					wb_pkg::FN_AND, wb_pkg::FN_SLT, wb_pkg::FN_SLTU: begin
						ctrl.grf_we = 1'b1;
					end
					default: begin
						ctrl.grf_we = 1'b0;
					end
				endcase
			end
			// Immediate ALU ops land in rt
			wb_pkg::OP_ORI, wb_pkg::OP_LUI, wb_pkg::OP_ADDI, wb_pkg::OP_ANDI: begin
				ctrl.grf_we   = 1'b1;
				ctrl.wreg_sel = wb_pkg::WREG_RT;
			end
			wb_pkg::OP_LW, wb_pkg::OP_LH, wb_pkg::OP_LB: begin
				ctrl.grf_we    = 1'b1;
				ctrl.wreg_sel  = wb_pkg::WREG_RT;
				ctrl.wdata_sel = wb_pkg::WDATA_MEM;
				ctrl.is_load   = 1'b1;
				if (opcode == wb_pkg::OP_LB) begin
					ctrl.load_kind = wb_pkg::LOAD_BYTE;
				end else if (opcode == wb_pkg::OP_LH) begin
					ctrl.load_kind = wb_pkg::LOAD_HALF;
				end
			end
			// Link address goes to $ra
			wb_pkg::OP_JAL: begin
				ctrl.grf_we    = 1'b1;
				ctrl.wreg_sel  = wb_pkg::WREG_RA;
				ctrl.wdata_sel = wb_pkg::WDATA_LINK;
				ctrl.is_jal    = 1'b1;
			end
			// Stores finished in M, nothing to retire here
			wb_pkg::OP_SB, wb_pkg::OP_SH: begin
				ctrl.grf_we = 1'b0;
			end
			default: begin
				ctrl.grf_we = 1'b0;
			end
		endcase
	end

	// Load and link are separate write-data paths
	a_load_jal_excl: assert final (!(ctrl.is_load && ctrl.is_jal))
		else $error("wb_decoder: is_load and is_jal both set");

endmodule

`default_nettype wire

// File: wb_pkg.sv
`default_nettype none

package wb_pkg;

	////////////////////////////////////////
	// Primary opcodes, instr[31:26]
	////////////////////////////////////////
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LH      = 6'b100001;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_SH      = 6'b101001;

	// Funct field for the special opcode, instr[5:0]
	localparam logic [5:0] FN_ADD  = 6'b100000;
	localparam logic [5:0] FN_SUB  = 6'b100010;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	////////////////////////////////////////
	// Write-back select encodings
	////////////////////////////////////////
	// Bit 1 marks jal, bit 0 marks a load
	typedef enum logic [1:0] {
		WDATA_ALU  = 2'd0,
		WDATA_MEM  = 2'd1,
		WDATA_LINK = 2'd2
	} wdata_sel_e;

	typedef enum logic [1:0] {
		WREG_RD = 2'd0,
		WREG_RT = 2'd1,
		WREG_RA = 2'd2
	} wreg_sel_e;

	typedef enum logic [1:0] {
		LOAD_WORD = 2'd0,
		LOAD_HALF = 2'd1,
		LOAD_BYTE = 2'd2
	} load_kind_e;

	////////////////////////////////////////
	// Stage bundles
	////////////////////////////////////////
	// Memory stage output, 131 bits
	typedef struct packed {
		logic        valid;
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] alu_result;
		logic [31:0] mem_rdata;
		logic [1:0]  byte_off;
	} mw_bundle_t;

	typedef struct packed {
		logic       grf_we;
		wdata_sel_e wdata_sel;
		wreg_sel_e  wreg_sel;
		load_kind_e load_kind;
		logic       is_jal;
		logic       is_load;
		logic [4:0] rt;
		logic [4:0] rd;
	} wb_ctrl_t;

	// Register file write port, also seen as the forwarding source
	typedef struct packed {
		logic        we;
		logic [4:0]  addr;
		logic [31:0] data;
	} grf_wr_t;

endpackage

`default_nettype wire

// File: wb_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage_top #(
	parameter int LINK_OFFSET = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               stall,
	input  logic               flush,
	input  wb_pkg::mw_bundle_t mw_in,
	input  logic [4:0]         ra1,
	input  logic [4:0]         ra2,
	output logic [31:0]        rd1,
	output logic [31:0]        rd2,
	output wb_pkg::grf_wr_t    fwd
);

	wb_pkg::mw_bundle_t w_bundle;
	wb_pkg::wb_ctrl_t   w_ctrl;
	wb_pkg::grf_wr_t    w_wr;

	////////////////////////////////////////
	// M/W buffer
	////////////////////////////////////////
	mw_pipe_reg u_mw_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.stall (stall),
		.flush (flush),
		.d     (mw_in),
		.q     (w_bundle)
	);

	////////////////////////////////////////
	// W-stage control and datapath
	////////////////////////////////////////
	wb_decoder u_dec (
		.instr (w_bundle.instr),
		.ctrl  (w_ctrl)
	);

	wb_datapath #(
		.LINK_OFFSET (LINK_OFFSET)
	) u_dp (
		.w    (w_bundle),
		.ctrl (w_ctrl),
		.wr   (w_wr)
	);

	// Register file, write port fed straight from W
	grf u_grf (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (w_wr),
		.ra1   (ra1),
		.ra2   (ra2),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	assign fwd = w_wr;

endmodule

`default_nettype wire

// File: wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_tb;

	localparam int LINK_OFFSET = 8;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] alu_result;
		logic [31:0] mem_rdata;
		logic [1:0]  byte_off;
		logic        stall;
		logic        flush;
		logic [4:0]  target;
		logic [31:0] expected;
	} test_t;

	logic clk;
	logic rst_n;
	logic stall;
	logic flush;
	logic check_en;
	logic [4:0] ra1;
	logic [4:0] ra2;
	logic [31:0] rd1;
	logic [31:0] rd2;
	logic [31:0] cur_exp;
	wb_pkg::mw_bundle_t mw_in;
	wb_pkg::grf_wr_t fwd;
	string cur_name = "reset";
	test_t tests[$];
	string names[$];
	int seed = 65951;
	int cycles = 0;
	int limit = 0;
	int errors;
	int tests_run;
	int tests_failed;

	wb_stage_top #(.LINK_OFFSET(LINK_OFFSET)) dut_i (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .mw_in(mw_in),
		.ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2), .fwd(fwd)
	);

	wb_checker #(.LINK_OFFSET(LINK_OFFSET)) check_i (
		.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .mw_in(mw_in),
		.ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2), .fwd(fwd), .test_name(cur_name),
		.exp_val(cur_exp), .check_en(check_en), .errors(errors), .tests_run(tests_run),
		.tests_failed(tests_failed)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Done: errors found");
			$finish;
		end
	end

	// R-type keeps rt at 9, I-type immediate puts 2 in the rd bits
	function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rd);
		return {wb_pkg::OP_SPECIAL, 5'd1, 5'd9, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt);
		return {op, 5'd1, rt, 16'h1234};
	endfunction

	task automatic add_test(input string nm, input logic [31:0] instr, input logic [31:0] pc,
		input logic [31:0] alu, input logic [31:0] mem, input logic [1:0] off,
		input logic stl, input logic fl, input logic [4:0] tgt, input logic [31:0] exp);
		tests.push_back({instr, pc, alu, mem, off, stl, fl, tgt, exp});
		names.push_back(nm);
	endtask

	task automatic add_alu(input string nm, input logic [31:0] instr, input logic [31:0] alu,
		input logic [4:0] tgt, input logic [31:0] exp);
		add_test(nm, instr, 32'h0, alu, 32'h0, 2'd0, 1'b0, 1'b0, tgt, exp);
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////
	task automatic build_table();
		logic [31:0] mem;
		logic [31:0] exp;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [1:0] off;
		logic [7:0] lane8;
		logic [15:0] lane16;
		r1 = $random(seed);
		r2 = $random(seed);
		add_alu("reset_r5", itype(6'h3f, 5'd5), 32'h12345678, 5'd5, 32'h0);
		add_alu("reset_r31", itype(6'h3f, 5'd31), 32'h12345678, 5'd31, 32'h0);
		add_alu("add_r3", rtype(wb_pkg::FN_ADD, 5'd3), 32'h11112222, 5'd3, 32'h11112222);
		add_alu("sub_r4", rtype(wb_pkg::FN_SUB, 5'd4), 32'hfffffff0, 5'd4, 32'hfffffff0);
		add_alu("or_r5", rtype(wb_pkg::FN_OR, 5'd5), 32'h0000ff0f, 5'd5, 32'h0000ff0f);
		add_alu("and_r6", rtype(wb_pkg::FN_AND, 5'd6), 32'h00f00000, 5'd6, 32'h00f00000);
		add_alu("slt_r7", rtype(wb_pkg::FN_SLT, 5'd7), 32'h1, 5'd7, 32'h1);
		add_alu("sltu_r8", rtype(wb_pkg::FN_SLTU, 5'd8), 32'h1, 5'd8, 32'h1);
		add_alu("ori_r9", itype(wb_pkg::OP_ORI, 5'd9), 32'h0000abcd, 5'd9, 32'h0000abcd);
		add_alu("lui_r10", itype(wb_pkg::OP_LUI, 5'd10), 32'habcd0000, 5'd10, 32'habcd0000);
		add_alu("addi_r11", itype(wb_pkg::OP_ADDI, 5'd11), 32'hffff8000, 5'd11, 32'hffff8000);
		add_alu("andi_r12", itype(wb_pkg::OP_ANDI, 5'd12), 32'h00000f00, 5'd12, 32'h00000f00);
		add_alu("sb_keeps_r3", itype(wb_pkg::OP_SB, 5'd3), 32'hdeadbeef, 5'd3, 32'h11112222);
		add_alu("sh_keeps_r4", itype(wb_pkg::OP_SH, 5'd4), 32'hdeadbeef, 5'd4, 32'hfffffff0);
		add_alu("bad_funct_r5", rtype(6'h3f, 5'd5), 32'hdeadbeef, 5'd5, 32'h0000ff0f);
		add_alu("bad_op_r6", itype(6'h3f, 5'd6), 32'hdeadbeef, 5'd6, 32'h00f00000);
		add_test("lw_r13", itype(wb_pkg::OP_LW, 5'd13), 32'h0, 32'h40, 32'h8badf00d, 2'd2,
			1'b0, 1'b0, 5'd13, 32'h8badf00d);
		add_test("jal_r31", itype(wb_pkg::OP_JAL, 5'd5), 32'h00400010, 32'h1234, 32'h0, 2'd0,
			1'b0, 1'b0, 5'd31, 32'h00400010 + 32'(LINK_OFFSET));
		add_alu("add_r0", rtype(wb_pkg::FN_ADD, 5'd0), 32'hdeadbeef, 5'd0, 32'h0);
		add_alu("ori_r0", itype(wb_pkg::OP_ORI, 5'd0), 32'h0000ffff, 5'd0, 32'h0);
		add_test("flush_r3", rtype(wb_pkg::FN_ADD, 5'd3), 32'h0, 32'h55555555, 32'h0, 2'd0,
			1'b0, 1'b1, 5'd3, 32'h11112222);
		add_test("stall_r9", itype(wb_pkg::OP_ADDI, 5'd9), 32'h0, 32'h0f0f0f0f, 32'h0, 2'd0,
			1'b1, 1'b0, 5'd9, 32'h0f0f0f0f);
		add_alu("bypass_r6", rtype(wb_pkg::FN_AND, 5'd6), 32'h12340000, 5'd6, 32'h12340000);
		add_alu("rand_r1", rtype(wb_pkg::FN_ADD, 5'd1), r1, 5'd1, r1);
		add_alu("rand_r2", rtype(wb_pkg::FN_OR, 5'd2), r2, 5'd2, r2);
		// Sub-word loads, each offset with the lane sign bit clear and set
		for (int k = 0; k < 16; k++) begin
			off = k[1:0];
			mem = $random(seed);
			if (k[3]) begin
				mem[off[1] ? 31 : 15] = k[2];
				lane16 = 16'(mem >> (16 * off[1]));
				exp = {{16{lane16[15]}}, lane16};
			end else begin
				mem[8 * off + 7] = k[2];
				lane8 = 8'(mem >> (8 * off));
				exp = {{24{lane8[7]}}, lane8};
			end
			add_test($sformatf("%s_off%0d_%s", k[3] ? "lh" : "lb", off, k[2] ? "neg" : "pos"),
				itype(k[3] ? wb_pkg::OP_LH : wb_pkg::OP_LB, 5'(14 + k)), 32'h0,
				$random(seed), mem, off, 1'b0, 1'b0, 5'(14 + k), exp);
		end
	endtask

	initial begin
		test_t t;
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		check_en = 1'b0;
		ra1 = 5'd0;
		ra2 = 5'd0;
		cur_exp = 32'h0;
		mw_in = '0;
		build_table();
		limit = tests.size() * 4 + 20;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		foreach (tests[i]) begin
			t = tests[i];
			@(posedge clk);
			#2;
			check_en = 1'b0;
			cur_name = names[i];
			cur_exp = t.expected;
			mw_in = {1'b1, t.instr, t.pc, t.alu_result, t.mem_rdata, t.byte_off};
			flush = t.flush;
			ra1 = t.target;
			// Port 2 walks the register file
			ra2 = 5'(i);
			@(posedge clk);
			#2;
			// Bubble behind the bundle, stall holds it one more cycle
			mw_in.valid = 1'b0;
			flush = 1'b0;
			stall = t.stall;
			@(posedge clk);
			#2;
			stall = 1'b0;
			@(posedge clk);
			#2;
			check_en = 1'b1;
		end
		@(posedge clk);
		#2;
		check_en = 1'b0;
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_run == tests.size()) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
